/* rtl/acc_pkg.sv */
////////////////////////////////////////
// accumulator package
// ring modulus, widths, branch count and the
// coefficient and digit types shared by the
// decomposition and key-multiply pipeline
////////////////////////////////////////

package acc_pkg;

    ////////////////////////////////////////
    // ring parameters
    ////////////////////////////////////////

    localparam int unsigned coeff_width = 14;     // holds any value below the modulus
    localparam int unsigned modulus     = 12289;  // every coefficient and key is below this

    ////////////////////////////////////////
    // decomposition parameters
    ////////////////////////////////////////

    // base 16 digits, balanced so each digit lies in -8 .. 7
    localparam int unsigned digit_bits       = 4;
    localparam int unsigned num_branches     = 4;  // four digits cover 16 bits of range
    localparam int unsigned branch_idx_width = 2;

    // digits, products and sum are each one register stage
    localparam int unsigned pipe_latency = 3;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // unsigned ring coefficient, also used for key words
    typedef logic [coeff_width-1:0] coeff_t;

    typedef logic signed [digit_bits-1:0] digit_t;

    // branch 0 sits in the least significant slot
    typedef digit_t [num_branches-1:0] digit_vec_t;

endpackage

/* rtl/digit_decompose.sv */
////////////////////////////////////////
// digit decompose
// splits an input coefficient into balanced
// signed base-16 digits, one per branch, and
// owns the input stream handshake
////////////////////////////////////////

`timescale 1ns/1ns

module digit_decompose (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   advance,   // whole pipeline moves this cycle
    input  logic                   in_valid,
    output logic                   in_ready,
    input  acc_pkg::coeff_t        in_coeff,
    output acc_pkg::digit_vec_t    digits,
    output logic                   s1_valid
);

    acc_pkg::digit_vec_t next_digits;

    // accepting a coefficient is only possible while the pipeline moves
    assign in_ready = advance;

    ////////////////////////////////////////
    // balanced base-16 decomposition
    ////////////////////////////////////////

    // the remainder never goes negative, since a negative digit only adds to it
    always_comb begin : decompose_chain
        logic signed [acc_pkg::coeff_width+1:0] rem;
        logic signed [acc_pkg::coeff_width+1:0] digit_ext;

        rem = {2'b00, in_coeff};
        for (int b = 0; b < acc_pkg::num_branches; b++) begin
            // low nibble read as signed is exactly the balanced digit
            next_digits[b] = acc_pkg::digit_t'(rem[acc_pkg::digit_bits-1:0]);
            digit_ext      = {{(acc_pkg::coeff_width + 2 - acc_pkg::digit_bits)
                                  {next_digits[b][acc_pkg::digit_bits-1]}},
                              next_digits[b]};
            rem            = (rem - digit_ext) >>> acc_pkg::digit_bits;  // exact division by 16
        end
    end

    ////////////////////////////////////////
    // stage one registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;  // ready equals advance, so valid here means accepted
        end
    end

    // digit payload just follows the pipeline
    always_ff @(posedge clk) begin
        if (advance) begin
            digits <= next_digits;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // an offered coefficient must be held until the pipeline takes it
    in_hold_check: assert property (
        @(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_coeff))
    ) else $error("input coefficient changed or valid dropped before acceptance");

endmodule

/* rtl/branch_key_mult.sv */
////////////////////////////////////////
// branch key multiply
// one decomposition lane: holds its key word and
// registers digit times key modulo the ring modulus
////////////////////////////////////////

`timescale 1ns/1ns

module branch_key_mult #(
    parameter int lane_index = 0  // which key slot and digit this lane owns
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     advance,
    input  logic                                     key_load,
    input  logic [acc_pkg::branch_idx_width-1:0]     key_branch,
    input  acc_pkg::coeff_t                          key_value,
    input  acc_pkg::digit_t                          digit,
    input  logic                                     digit_valid,
    output acc_pkg::coeff_t                          product,
    output logic                                     product_valid
);

    acc_pkg::coeff_t                                      key_word;
    logic [acc_pkg::digit_bits-1:0]                       magnitude;
    logic [acc_pkg::coeff_width+acc_pkg::digit_bits-1:0]  raw_product;
    acc_pkg::coeff_t                                      reduced;
    acc_pkg::coeff_t                                      next_product;
    logic                                                 digit_negative;

    ////////////////////////////////////////
    // key slot
    ////////////////////////////////////////

    // keys change only with nothing in flight, so no interlock with advance
    always_ff @(posedge clk) begin
        if (key_load && (int'(key_branch) == lane_index)) begin
            key_word <= key_value;
        end
    end

    ////////////////////////////////////////
    // signed modular multiply
    ////////////////////////////////////////

    assign digit_negative = digit[acc_pkg::digit_bits-1];

    // -8 negates to itself in 4 bits, which is still 8 read unsigned
    assign magnitude   = digit_negative ? -digit : digit;
    assign raw_product = magnitude * key_word;  // at most 8 * 12288, fits 18 bits
    assign reduced     = acc_pkg::coeff_t'(raw_product % acc_pkg::modulus);

    // negate in the ring, keeping zero as zero
    always_comb begin
        if (digit_negative && (reduced != '0)) begin
            next_product = acc_pkg::coeff_t'(acc_pkg::modulus) - reduced;
        end else begin
            next_product = reduced;
        end
    end

    ////////////////////////////////////////
    // stage two registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            product_valid <= 1'b0;
        end else if (advance) begin
            product_valid <= digit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            product <= next_product;
        end
    end

    // a key loaded out of range would break the adder tree downstream
    product_range_check: assert property (
        @(posedge clk) disable iff (reset)
        product_valid |-> (product < acc_pkg::modulus)
    ) else $error("lane %0d product 0x%h not below modulus", lane_index, product);

endmodule

/* rtl/branch_sum.sv */
////////////////////////////////////////
// branch sum
// adds the branch products modulo the ring
// modulus and owns the output stream handshake
////////////////////////////////////////

`timescale 1ns/1ns

module branch_sum (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        advance,
    input  acc_pkg::coeff_t [acc_pkg::num_branches-1:0] products,
    input  logic                                        products_valid,
    output logic                                        out_valid,
    input  logic                                        out_ready,
    output acc_pkg::coeff_t                             out_coeff
);

    acc_pkg::coeff_t total;

    // both operands are below the modulus, so one subtraction is enough
    function automatic acc_pkg::coeff_t mod_add(input acc_pkg::coeff_t a,
                                                input acc_pkg::coeff_t b);
        logic [acc_pkg::coeff_width:0] sum;

        sum = {1'b0, a} + {1'b0, b};
        if (sum >= acc_pkg::modulus) begin
            sum = sum - (acc_pkg::coeff_width + 1)'(acc_pkg::modulus);
        end
        return acc_pkg::coeff_t'(sum);
    endfunction

    ////////////////////////////////////////
    // pairwise adder tree
    ////////////////////////////////////////

    always_comb begin : adder_tree
        acc_pkg::coeff_t level [acc_pkg::num_branches];

        for (int i = 0; i < acc_pkg::num_branches; i++) begin
            level[i] = products[i];
        end
        // each pass folds neighbours step apart, leaving the sum in slot 0
        for (int step = 1; step < acc_pkg::num_branches; step = step * 2) begin
            for (int i = 0; i + step < acc_pkg::num_branches; i = i + 2 * step) begin
                level[i] = mod_add(level[i], level[i+step]);
            end
        end
        total = level[0];
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= products_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_coeff <= total;  // advance is low while a result waits, so it holds
        end
    end

    out_hold_check: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_coeff))
    ) else $error("output result changed while stalled");

endmodule

/* rtl/key_accumulate_top.sv */
////////////////////////////////////////
// key accumulate top
// decompose, per-branch key multiply and modular
// sum as a three stage streaming pipeline
////////////////////////////////////////

`timescale 1ns/1ns

module key_accumulate_top (
    input  logic                                 clk,
    input  logic                                 reset,
    // coefficient input stream
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  acc_pkg::coeff_t                      in_coeff,
    // key load port
    input  logic                                 key_load,
    input  logic [acc_pkg::branch_idx_width-1:0] key_branch,
    input  acc_pkg::coeff_t                      key_value,
    // result output stream
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output acc_pkg::coeff_t                      out_coeff
);

    logic                                        advance;
    acc_pkg::digit_vec_t                         digits;
    logic                                        s1_valid;
    acc_pkg::coeff_t [acc_pkg::num_branches-1:0] products;
    logic [acc_pkg::num_branches-1:0]            lane_valid;
    logic                                        s2_valid;

    // shared stall, every stage moves or holds together
    assign advance  = !out_valid || out_ready;
    assign s2_valid = lane_valid[0];  // lanes move in lockstep

    ////////////////////////////////////////
    // stage one
    ////////////////////////////////////////

    digit_decompose digit_decompose_inst (
        .clk      (clk),
        .reset    (reset),
        .advance  (advance),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_coeff (in_coeff),
        .digits   (digits),
        .s1_valid (s1_valid)
    );

    ////////////////////////////////////////
    // stage two, one lane per branch
    ////////////////////////////////////////

    for (genvar g = 0; g < acc_pkg::num_branches; g++) begin : gen_lane
        branch_key_mult #(
            .lane_index (g)
        ) branch_key_mult_inst (
            .clk           (clk),
            .reset         (reset),
            .advance       (advance),
            .key_load      (key_load),
            .key_branch    (key_branch),
            .key_value     (key_value),
            .digit         (digits[g]),
            .digit_valid   (s1_valid),
            .product       (products[g]),
            .product_valid (lane_valid[g])
        );
    end

    ////////////////////////////////////////
    // stage three
    ////////////////////////////////////////

    branch_sum branch_sum_inst (
        .clk            (clk),
        .reset          (reset),
        .advance        (advance),
        .products       (products),
        .products_valid (s2_valid),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_coeff      (out_coeff)
    );

endmodule

/* test/acc_checker.sv */
////////////////////////////////////////
// accumulator checker
// watches the DUT ports, models each result with
// the balanced digit rule and compares in order
////////////////////////////////////////

`timescale 1ns/1ns

module acc_checker (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 in_valid,
    input  logic                                 in_ready,
    input  acc_pkg::coeff_t                      in_coeff,
    input  logic                                 key_load,
    input  logic [acc_pkg::branch_idx_width-1:0] key_branch,
    input  acc_pkg::coeff_t                      key_value,
    input  logic                                 out_valid,
    input  logic                                 out_ready,
    input  acc_pkg::coeff_t                      out_coeff,
    input  acc_pkg::coeff_t                      table_expect,        // row value from the testbench
    input  logic                                 table_expect_valid,
    output int                                   pending,
    output int                                   value_errors,
    output int                                   latency_errors,
    output int                                   other_errors
);

    int key_mirror [acc_pkg::num_branches];
    int expect_q [$];
    int accept_q [$];   // cycle on which each queued input was taken
    int stall_q [$];    // stall count seen at that same moment
    int cycle;
    int stalls;
    bit seen_input;

    // sum of digit times key, digits taken least significant first
    function automatic int expected_result(input int value);
        int base;
        int r;
        int res;
        int d;
        int acc;

        base = 1 << acc_pkg::digit_bits;
        r    = value;
        acc  = 0;
        for (int b = 0; b < acc_pkg::num_branches; b++) begin
            res = r % base;
            d   = (res >= base / 2) ? res - base : res;
            r   = (r - d) / base;
            acc = acc + d * key_mirror[b];
        end
        acc = acc % int'(acc_pkg::modulus);
        if (acc < 0) begin
            acc = acc + int'(acc_pkg::modulus);
        end
        return acc;
    endfunction

    initial begin
        value_errors   = 0;
        latency_errors = 0;
        other_errors   = 0;
        pending        = 0;
        cycle          = 0;
        stalls         = 0;
        seen_input     = 1'b0;
    end

    ////////////////////////////////////////
    // per-edge sampling
    ////////////////////////////////////////

    always @(posedge clk) begin
        int exp_value;
        int accepted_at;
        int stall_mark;
        int want;
        int model;

        if (!reset) begin
            cycle = cycle + 1;
            if (key_load) begin
                key_mirror[key_branch] = int'(key_value);
            end
            if (!seen_input && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
                other_errors++;
                $display("pipeline not idle after reset at cycle %0d", cycle);
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    other_errors++;
                    $display("result 0x%h came out with no input waiting for it", out_coeff);
                end else begin
                    exp_value   = expect_q.pop_front();
                    accepted_at = accept_q.pop_front();
                    stall_mark  = stall_q.pop_front();
                    if (int'(out_coeff) != exp_value) begin
                        value_errors++;
                        $display("Error: out_coeff expected 0x%h got 0x%h", exp_value, out_coeff);
                    end
                    // every stalled edge holds the whole pipeline for one cycle
                    want = int'(acc_pkg::pipe_latency) + (stalls - stall_mark);
                    if (cycle - accepted_at != want) begin
                        latency_errors++;
                        $display("result 0x%h took %0d cycles instead of %0d",
                                 out_coeff, cycle - accepted_at, want);
                    end
                end
            end
            if (out_valid && !out_ready) begin
                stalls = stalls + 1;
            end
            if (in_valid && in_ready) begin
                seen_input = 1'b1;
                model      = expected_result(int'(in_coeff));
                if (table_expect_valid && int'(table_expect) != model) begin
                    other_errors++;
                    $display("table row for input 0x%h disagrees with the digit model", in_coeff);
                end
                expect_q.push_back(table_expect_valid ? int'(table_expect) : model);
                accept_q.push_back(cycle);
                stall_q.push_back(stalls);
            end
            pending = expect_q.size();
        end
    end

endmodule

/* test/tb_key_accumulate.sv */
////////////////////////////////////////
// key accumulate testbench
// loads key sets, runs the stimulus table and a
// random back-pressure phase through the DUT
////////////////////////////////////////

`timescale 1ns/1ns

module tb_key_accumulate;

    localparam int random_count = 200;

    logic                                 clk;
    logic                                 reset;
    logic                                 in_valid;
    logic                                 in_ready;
    acc_pkg::coeff_t                      in_coeff;
    logic                                 key_load;
    logic [acc_pkg::branch_idx_width-1:0] key_branch;
    acc_pkg::coeff_t                      key_value;
    logic                                 out_valid;
    logic                                 out_ready;
    acc_pkg::coeff_t                      out_coeff;
    acc_pkg::coeff_t                      table_expect;
    logic                                 table_expect_valid;
    logic                                 random_ready;   // back-pressure on or off
    int                                   pending;
    int                                   value_errors;
    int                                   latency_errors;
    int                                   other_errors;
    int                                   watchdog_cycles;
    int unsigned                          seed = 32'h7690;

    // four key words per row, then the coefficient and its result
    acc_pkg::coeff_t row_keys [$];
    acc_pkg::coeff_t row_coeff [$];
    acc_pkg::coeff_t row_expect [$];

    key_accumulate_top key_accumulate_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_coeff   (in_coeff),
        .key_load   (key_load),
        .key_branch (key_branch),
        .key_value  (key_value),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_coeff  (out_coeff)
    );

    acc_checker acc_checker (
        .clk                (clk),
        .reset              (reset),
        .in_valid           (in_valid),
        .in_ready           (in_ready),
        .in_coeff           (in_coeff),
        .key_load           (key_load),
        .key_branch         (key_branch),
        .key_value          (key_value),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_coeff          (out_coeff),
        .table_expect       (table_expect),
        .table_expect_valid (table_expect_valid),
        .pending            (pending),
        .value_errors       (value_errors),
        .latency_errors     (latency_errors),
        .other_errors       (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic add_row(input int k0, input int k1, input int k2, input int k3,
                           input int coeff, input int result);
        row_keys.push_back(acc_pkg::coeff_t'(k0));
        row_keys.push_back(acc_pkg::coeff_t'(k1));
        row_keys.push_back(acc_pkg::coeff_t'(k2));
        row_keys.push_back(acc_pkg::coeff_t'(k3));
        row_coeff.push_back(acc_pkg::coeff_t'(coeff));
        row_expect.push_back(acc_pkg::coeff_t'(result));
    endtask

    // identity weights, k = 3 weights, arbitrary weights, all minus one
    task automatic build_table();
        int values [7] = '{0, 1, 8, 12288, 6144, 4095, 7999};
        int scaled [7] = '{0, 3, 24, 12286, 6143, 12285, 11708};
        int mixed [7]  = '{0, 5, 60, 21, 4303, 2, 11698};
        int negated [7] = '{0, 12288, 7, 12286, 6, 0, 12285};

        for (int i = 0; i < 7; i++) add_row(1, 16, 256, 4096, values[i], values[i]);
        for (int i = 0; i < 7; i++) add_row(3, 48, 768, 12288, values[i], scaled[i]);
        for (int i = 0; i < 7; i++) add_row(5, 100, 1000, 7, values[i], mixed[i]);
        for (int i = 0; i < 7; i++) add_row(12288, 12288, 12288, 12288, values[i], negated[i]);
    endtask

    function automatic bit keys_change(input int row);
        if (row == 0) begin
            return 1'b1;
        end
        for (int b = 0; b < acc_pkg::num_branches; b++) begin
            if (row_keys[4 * row + b] != row_keys[4 * (row - 1) + b]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // all calls start and end 1 ns after a rising edge
    task automatic load_keys(input acc_pkg::coeff_t k0, input acc_pkg::coeff_t k1,
                             input acc_pkg::coeff_t k2, input acc_pkg::coeff_t k3);
        acc_pkg::coeff_t words [acc_pkg::num_branches];

        words = '{k0, k1, k2, k3};
        for (int b = 0; b < acc_pkg::num_branches; b++) begin
            key_load   = 1'b1;
            key_branch = (acc_pkg::branch_idx_width)'(b);
            key_value  = words[b];
            @(posedge clk);
            #1;
        end
        key_load = 1'b0;
    endtask

    task automatic send_coeff(input acc_pkg::coeff_t value);
        in_valid = 1'b1;
        in_coeff = value;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic drain_pipeline();
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        out_ready = random_ready ? (($urandom % 2) == 1) : 1'b1;
    end

    initial begin
        int unsigned seed_draw;

        seed_draw          = $urandom(seed);
        reset              = 1'b1;
        in_valid           = 1'b0;
        in_coeff           = '0;
        key_load           = 1'b0;
        key_branch         = '0;
        key_value          = '0;
        out_ready          = 1'b1;
        table_expect       = '0;
        table_expect_valid = 1'b0;
        random_ready       = 1'b0;
        build_table();
        watchdog_cycles = (row_coeff.size() + random_count) * 20 + 100;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // rows sharing a key set go in back to back
        for (int row = 0; row < row_coeff.size(); row++) begin
            if (keys_change(row)) begin
                in_valid           = 1'b0;
                table_expect_valid = 1'b0;
                drain_pipeline();
                load_keys(row_keys[4 * row], row_keys[4 * row + 1],
                          row_keys[4 * row + 2], row_keys[4 * row + 3]);
            end
            table_expect       = row_expect[row];
            table_expect_valid = 1'b1;
            send_coeff(row_coeff[row]);
        end
        in_valid           = 1'b0;
        table_expect_valid = 1'b0;
        drain_pipeline();

        load_keys(acc_pkg::coeff_t'($urandom % acc_pkg::modulus),
                  acc_pkg::coeff_t'($urandom % acc_pkg::modulus),
                  acc_pkg::coeff_t'($urandom % acc_pkg::modulus),
                  acc_pkg::coeff_t'($urandom % acc_pkg::modulus));
        random_ready = 1'b1;
        repeat (random_count) send_coeff(acc_pkg::coeff_t'($urandom % acc_pkg::modulus));
        in_valid = 1'b0;
        drain_pipeline();
        random_ready = 1'b0;

        // a stray extra result would leave the pipeline within its depth
        repeat (acc_pkg::pipe_latency + 1) @(posedge clk);
        #1;

        $display("value errors %0d, latency errors %0d, other errors %0d",
                 value_errors, latency_errors, other_errors);
        if (value_errors + latency_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // the limit is known once the table is built
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles, %0d results still outstanding",
                 watchdog_cycles, pending);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* list.f */
rtl/acc_pkg.sv
rtl/digit_decompose.sv
rtl/branch_key_mult.sv
rtl/branch_sum.sv
rtl/key_accumulate_top.sv
test/acc_checker.sv
test/tb_key_accumulate.sv

/* Bender.yml */
package:
  name: key_accumulate

sources:
  - files:
      - rtl/acc_pkg.sv
      - rtl/digit_decompose.sv
      - rtl/branch_key_mult.sv
      - rtl/branch_sum.sv
      - rtl/key_accumulate_top.sv
  - target: test
    files:
      - test/acc_checker.sv
      - test/tb_key_accumulate.sv
